// ==== common/tile_settings.svh ====
/*
 * Integer tile build settings
 * Dispatch group size, lane count, data and register widths
 */

`ifndef TILE_SETTINGS_SVH
`define TILE_SETTINGS_SVH

// ------------------------------------------------------------
// Dispatch and execution resources
// ------------------------------------------------------------
// Lane count has to follow the dispatch width
`define TILE_DISP_SIZE 2
`define TILE_LANE_NUM  2

// ------------------------------------------------------------
// Datapath widths
// ------------------------------------------------------------
`define TILE_XLEN      32
`define TILE_PREG_NUM  32
`define TILE_IMM_W     16

`endif

// ==== common/tile_pkg.sv ====
/*
 * Integer tile types
 * Data, register index and immediate vectors, ALU opcodes,
 * issued instruction and writeback records
 */

`include "tile_settings.svh"

package tile_pkg;

  typedef logic [`TILE_XLEN-1:0]              xlen_t;
  typedef logic [$clog2(`TILE_PREG_NUM)-1:0]  rnid_t;
  typedef logic [`TILE_IMM_W-1:0]             imm_t;

  // ------------------------------------------------------------
  // ALU opcodes
  // ------------------------------------------------------------
  // Codes above OP_LI are illegal
  typedef enum logic [3:0] {
    OP_ADD = 4'd0,
    OP_SUB = 4'd1,
    OP_AND = 4'd2,
    OP_OR  = 4'd3,
    OP_XOR = 4'd4,
    OP_SLL = 4'd5,
    OP_SRL = 4'd6,
    OP_LI  = 4'd7
  } alu_op_t;

  // One instruction of a dispatch group or on a lane
  typedef struct packed {
    logic    valid;
    alu_op_t op;
    rnid_t   rd;
    rnid_t   rs1;
    rnid_t   rs2;
    imm_t    imm;
  } disp_inst_t;

  // Register file writeback
  typedef struct packed {
    logic  valid;
    rnid_t rnid;
    xlen_t data;
  } phy_wr_t;

endpackage

// ==== common/regread_if.sv ====
/*
 * Register read port between an ALU lane and the register file
 */

`timescale 1ns/10ps

`include "tile_settings.svh"

interface regread_if;

  tile_pkg::rnid_t rs1_rnid;
  tile_pkg::rnid_t rs2_rnid;
  tile_pkg::xlen_t rs1_data;
  tile_pkg::xlen_t rs2_data;

  // Lane side sends indexes
  modport lane (
    output rs1_rnid,
    output rs2_rnid,
    input  rs1_data,
    input  rs2_data
  );

  // Register file side returns data in the same cycle
  modport regfile (
    input  rs1_rnid,
    input  rs2_rnid,
    output rs1_data,
    output rs2_data
  );

endinterface

// ==== hdl/alu_dispatch.sv ====
/*
 * ALU dispatcher
 * Flags illegal opcodes and packs the legal slots onto lanes in slot order
 */

`timescale 1ns/10ps

`include "tile_settings.svh"

module alu_dispatch (
  input  logic                 i_clk,
  input  logic                 i_reset,
  input  tile_pkg::disp_inst_t i_group[`TILE_DISP_SIZE],
  output logic [`TILE_DISP_SIZE-1:0] o_illegal,
  output tile_pkg::disp_inst_t o_lane_inst[`TILE_LANE_NUM]
);

  logic [`TILE_DISP_SIZE-1:0] w_illegal;
  logic [`TILE_DISP_SIZE-1:0] w_legal;
  tile_pkg::disp_inst_t       w_lane_inst[`TILE_LANE_NUM];

  logic [`TILE_LANE_NUM-1:0]  r_lane_vld;
  tile_pkg::disp_inst_t       r_lane_inst[`TILE_LANE_NUM];

  // ------------------------------------------------------------
  // Decode
  // ------------------------------------------------------------
  generate for (genvar s_idx = 0; s_idx < `TILE_DISP_SIZE; s_idx++) begin : slot_loop
    assign w_illegal[s_idx] = i_group[s_idx].valid & (i_group[s_idx].op > tile_pkg::OP_LI);
    assign w_legal[s_idx]   = i_group[s_idx].valid & ~w_illegal[s_idx];
  end endgenerate

  // Lowest legal slot takes lane 0, the next one lane 1
  always_comb begin : steer
    int unsigned lane_idx;
    lane_idx = 0;
    for (int l = 0; l < `TILE_LANE_NUM; l++) begin
      w_lane_inst[l] = '0;
    end
    for (int s = 0; s < `TILE_DISP_SIZE; s++) begin
      if (w_legal[s]) begin
        if (lane_idx < `TILE_LANE_NUM) begin
          w_lane_inst[lane_idx] = i_group[s];
        end
        lane_idx++;
      end
    end
  end

  // ------------------------------------------------------------
  // Issue registers
  // ------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_illegal  <= '0;
      r_lane_vld <= '0;
    end else begin
      o_illegal <= w_illegal;
      for (int l = 0; l < `TILE_LANE_NUM; l++) begin
        r_lane_vld[l] <= w_lane_inst[l].valid;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    for (int l = 0; l < `TILE_LANE_NUM; l++) begin
      r_lane_inst[l] <= w_lane_inst[l];
    end
  end

  always_comb begin
    for (int l = 0; l < `TILE_LANE_NUM; l++) begin
      o_lane_inst[l]       = r_lane_inst[l];
      o_lane_inst[l].valid = r_lane_vld[l];
    end
  end

endmodule

// ==== alu/alu_lane.sv ====
/*
 * Single ALU lane
 * ex1 reads operands, ex2 executes and registers the writeback
 */

`timescale 1ns/10ps

`include "tile_settings.svh"

module alu_lane (
  input  logic                 i_clk,
  input  logic                 i_reset,
  input  tile_pkg::disp_inst_t i_inst,
  regread_if.lane              regread,
  output tile_pkg::phy_wr_t    o_phy_wr
);

  localparam int SHAMT_W = $clog2(`TILE_XLEN);

  // ex1 stage
  logic              r_ex1_valid;
  tile_pkg::alu_op_t r_ex1_op;
  tile_pkg::rnid_t   r_ex1_rd;
  tile_pkg::imm_t    r_ex1_imm;
  tile_pkg::xlen_t   r_ex1_rs1;
  tile_pkg::xlen_t   r_ex1_rs2;

  // ex2 stage
  tile_pkg::xlen_t   w_ex2_result;
  logic              r_ex2_valid;
  tile_pkg::rnid_t   r_ex2_rd;
  tile_pkg::xlen_t   r_ex2_data;

  // ------------------------------------------------------------
  // ex1 operand read
  // ------------------------------------------------------------
  assign regread.rs1_rnid = i_inst.rs1;
  assign regread.rs2_rnid = i_inst.rs2;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_ex1_valid <= 1'b0;
    end else begin
      r_ex1_valid <= i_inst.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex1_op  <= i_inst.op;
    r_ex1_rd  <= i_inst.rd;
    r_ex1_imm <= i_inst.imm;
    r_ex1_rs1 <= regread.rs1_data;
    r_ex1_rs2 <= regread.rs2_data;
  end

  // ------------------------------------------------------------
  // ex2 execute
  // ------------------------------------------------------------
  always_comb begin : alu_exec
    case (r_ex1_op)
      tile_pkg::OP_ADD: w_ex2_result = r_ex1_rs1 + r_ex1_rs2;
      tile_pkg::OP_SUB: w_ex2_result = r_ex1_rs1 - r_ex1_rs2;
      tile_pkg::OP_AND: w_ex2_result = r_ex1_rs1 & r_ex1_rs2;
      tile_pkg::OP_OR:  w_ex2_result = r_ex1_rs1 | r_ex1_rs2;
      tile_pkg::OP_XOR: w_ex2_result = r_ex1_rs1 ^ r_ex1_rs2;
      // Shift amount from low bits of rs2
      tile_pkg::OP_SLL: w_ex2_result = r_ex1_rs1 << r_ex1_rs2[SHAMT_W-1:0];
      tile_pkg::OP_SRL: w_ex2_result = r_ex1_rs1 >> r_ex1_rs2[SHAMT_W-1:0];
      tile_pkg::OP_LI: begin
        w_ex2_result = {{(`TILE_XLEN-`TILE_IMM_W){r_ex1_imm[`TILE_IMM_W-1]}}, r_ex1_imm};
      end
      default: w_ex2_result = '0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_ex2_valid <= 1'b0;
    end else begin
      r_ex2_valid <= r_ex1_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex2_rd   <= r_ex1_rd;
    r_ex2_data <= w_ex2_result;
  end

  // Writeback record
  assign o_phy_wr.valid = r_ex2_valid;
  assign o_phy_wr.rnid  = r_ex2_rd;
  assign o_phy_wr.data  = r_ex2_data;

endmodule

// ==== regfile/phy_regfile.sv ====
/*
 * Physical integer register file
 * Two combinational reads and one write per lane
 */

`timescale 1ns/10ps

`include "tile_settings.svh"

module phy_regfile (
  input  logic              i_clk,
  input  logic              i_reset,
  regread_if.regfile        regread[`TILE_LANE_NUM],
  input  tile_pkg::phy_wr_t i_phy_wr[`TILE_LANE_NUM]
);

  tile_pkg::xlen_t r_regs[`TILE_PREG_NUM];

  // ------------------------------------------------------------
  // Read ports
  // ------------------------------------------------------------
  // Old value is returned when a write lands on the same edge
  generate for (genvar l_idx = 0; l_idx < `TILE_LANE_NUM; l_idx++) begin : rd_port_loop
    assign regread[l_idx].rs1_data = r_regs[regread[l_idx].rs1_rnid];
    assign regread[l_idx].rs2_data = r_regs[regread[l_idx].rs2_rnid];
  end endgenerate

  // ------------------------------------------------------------
  // Write ports
  // ------------------------------------------------------------
  // Ascending lane order, so the higher lane wins a shared rnid
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int r = 0; r < `TILE_PREG_NUM; r++) begin
        r_regs[r] <= '0;
      end
    end else begin
      for (int l = 0; l < `TILE_LANE_NUM; l++) begin
        if (i_phy_wr[l].valid) begin
          r_regs[i_phy_wr[l].rnid] <= i_phy_wr[l].data;
        end
      end
    end
  end

endmodule

// ==== hdl/alu_tile.sv ====
/*
 * Integer tile top
 * Dispatcher, ALU lane array and physical register file
 */

`timescale 1ns/10ps

`include "tile_settings.svh"

module alu_tile (
  input  logic                                            i_clk,
  input  logic                                            i_reset,
  input  logic [`TILE_DISP_SIZE-1:0]                      i_disp_valid,
  input  logic [`TILE_DISP_SIZE-1:0][$bits(tile_pkg::alu_op_t)-1:0] i_disp_op,
  input  tile_pkg::rnid_t [`TILE_DISP_SIZE-1:0]           i_disp_rd,
  input  tile_pkg::rnid_t [`TILE_DISP_SIZE-1:0]           i_disp_rs1,
  input  tile_pkg::rnid_t [`TILE_DISP_SIZE-1:0]           i_disp_rs2,
  input  tile_pkg::imm_t  [`TILE_DISP_SIZE-1:0]           i_disp_imm,
  output logic [`TILE_DISP_SIZE-1:0]                      o_illegal,
  output logic [`TILE_LANE_NUM-1:0]                       o_wb_valid,
  output tile_pkg::rnid_t [`TILE_LANE_NUM-1:0]            o_wb_rnid,
  output tile_pkg::xlen_t [`TILE_LANE_NUM-1:0]            o_wb_data
);

  tile_pkg::disp_inst_t w_group[`TILE_DISP_SIZE];
  tile_pkg::disp_inst_t w_lane_inst[`TILE_LANE_NUM];
  tile_pkg::phy_wr_t    w_phy_wr[`TILE_LANE_NUM];

  regread_if w_regread[`TILE_LANE_NUM] ();

  // Dispatch group from the slot ports
  generate for (genvar s_idx = 0; s_idx < `TILE_DISP_SIZE; s_idx++) begin : group_loop
    assign w_group[s_idx].valid = i_disp_valid[s_idx];
    assign w_group[s_idx].op    = tile_pkg::alu_op_t'(i_disp_op[s_idx]);
    assign w_group[s_idx].rd    = i_disp_rd[s_idx];
    assign w_group[s_idx].rs1   = i_disp_rs1[s_idx];
    assign w_group[s_idx].rs2   = i_disp_rs2[s_idx];
    assign w_group[s_idx].imm   = i_disp_imm[s_idx];
  end endgenerate

  alu_dispatch u_dispatch (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_group     (w_group),
    .o_illegal   (o_illegal),
    .o_lane_inst (w_lane_inst)
  );

  // ------------------------------------------------------------
  // ALU lanes
  // ------------------------------------------------------------
  generate for (genvar l_idx = 0; l_idx < `TILE_LANE_NUM; l_idx++) begin : lane_loop
    alu_lane u_lane (
      .i_clk    (i_clk),
      .i_reset  (i_reset),
      .i_inst   (w_lane_inst[l_idx]),
      .regread  (w_regread[l_idx]),
      .o_phy_wr (w_phy_wr[l_idx])
    );

    assign o_wb_valid[l_idx] = w_phy_wr[l_idx].valid;
    assign o_wb_rnid[l_idx]  = w_phy_wr[l_idx].rnid;
    assign o_wb_data[l_idx]  = w_phy_wr[l_idx].data;
  end endgenerate

  phy_regfile u_regfile (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .regread  (w_regread),
    .i_phy_wr (w_phy_wr)
  );

endmodule

// ==== tb/tb_alu_tile.sv ====
/*
 * Directed testbench for the integer tile
 * Register model, writeback scoreboard, LCG operands and watchdog
 */

`timescale 1ns/10ps

`include "tile_settings.svh"

module tb_alu_tile;

  localparam int CLK_PERIOD = 20;
  localparam int DS         = `TILE_DISP_SIZE;
  localparam int LN         = `TILE_LANE_NUM;

  // Cycle budget per test
  localparam int RESET_CYC    = 4;
  localparam int RST_TEST_CYC = 12;
  localparam int OPS_CYC      = 24;
  localparam int STEER_CYC    = 16;
  localparam int ILL_CYC      = 26;
  localparam int CONF_CYC     = 24;
  localparam int MARGIN_CYC   = 50;
  localparam int WATCHDOG_CYC = RESET_CYC + RST_TEST_CYC + OPS_CYC + STEER_CYC + ILL_CYC
                                + CONF_CYC + MARGIN_CYC;

  typedef struct packed {
    int unsigned     at_edge;
    int unsigned     lane;
    tile_pkg::rnid_t rnid;
    tile_pkg::xlen_t data;
  } wb_exp_t;

  typedef struct packed {
    int unsigned   at_edge;
    logic [DS-1:0] mask;
  } ill_exp_t;

  logic                     i_clk;
  logic                     i_reset;
  logic [DS-1:0]            i_disp_valid;
  logic [DS-1:0][3:0]       i_disp_op;
  tile_pkg::rnid_t [DS-1:0] i_disp_rd;
  tile_pkg::rnid_t [DS-1:0] i_disp_rs1;
  tile_pkg::rnid_t [DS-1:0] i_disp_rs2;
  tile_pkg::imm_t  [DS-1:0] i_disp_imm;
  logic [DS-1:0]            o_illegal;
  logic [LN-1:0]            o_wb_valid;
  tile_pkg::rnid_t [LN-1:0] o_wb_rnid;
  tile_pkg::xlen_t [LN-1:0] o_wb_data;

  // Next group to issue
  logic [DS-1:0]            slot_valid;
  logic [DS-1:0][3:0]       slot_op;
  tile_pkg::rnid_t [DS-1:0] slot_rd;
  tile_pkg::rnid_t [DS-1:0] slot_rs1;
  tile_pkg::rnid_t [DS-1:0] slot_rs2;
  tile_pkg::imm_t  [DS-1:0] slot_imm;

  tile_pkg::xlen_t model_regs[`TILE_PREG_NUM];
  wb_exp_t         wb_q[$];
  wb_exp_t         wr_q[$];
  ill_exp_t        ill_q[$];

  int unsigned     edge_cnt;
  int unsigned     check_cnt;
  int unsigned     error_cnt;
  int unsigned     busy_cnt;
  logic [31:0]     lcg_state;

  logic [LN-1:0]   mon_valid;
  tile_pkg::rnid_t mon_rnid[LN];
  tile_pkg::xlen_t mon_data[LN];
  logic [DS-1:0]   mon_ill;

  alu_tile dut0 (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_disp_valid (i_disp_valid),
    .i_disp_op    (i_disp_op),
    .i_disp_rd    (i_disp_rd),
    .i_disp_rs1   (i_disp_rs1),
    .i_disp_rs2   (i_disp_rs2),
    .i_disp_imm   (i_disp_imm),
    .o_illegal    (o_illegal),
    .o_wb_valid   (o_wb_valid),
    .o_wb_rnid    (o_wb_rnid),
    .o_wb_data    (o_wb_data)
  );

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic tile_pkg::rnid_t rand_src();
    return tile_pkg::rnid_t'(32'd1 + next_rand() % 32'd8);
  endfunction

  // Expected result of one legal opcode
  function automatic tile_pkg::xlen_t alu_model(logic [3:0] op, tile_pkg::xlen_t a,
                                                tile_pkg::xlen_t b, tile_pkg::imm_t imm);
    case (op)
      4'd0: return a + b;
      4'd1: return a - b;
      4'd2: return a & b;
      4'd3: return a | b;
      4'd4: return a ^ b;
      4'd5: return a << b[4:0];
      4'd6: return a >> b[4:0];
      4'd7: return 32'($signed(imm));
      default: return '0;
    endcase
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    check_cnt++;
    assert (act_v === exp_v) else begin
      error_cnt++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
    end
  endtask

  task automatic set_slot(input int s, input logic [3:0] op, input tile_pkg::rnid_t rd,
                          input tile_pkg::rnid_t rs1, input tile_pkg::rnid_t rs2,
                          input tile_pkg::imm_t imm);
    slot_valid[s] = 1'b1;
    slot_op[s]    = op;
    slot_rd[s]    = rd;
    slot_rs1[s]   = rs1;
    slot_rs2[s]   = rs2;
    slot_imm[s]   = imm;
  endtask

  // Drive the staged group and queue its expected responses
  task automatic issue();
    int unsigned   n_edge;
    int unsigned   lane;
    wb_exp_t       ent;
    ill_exp_t      ill_ent;
    logic [DS-1:0] ill;
    @(posedge i_clk);
    i_disp_valid <= slot_valid;
    i_disp_op    <= slot_op;
    i_disp_rd    <= slot_rd;
    i_disp_rs1   <= slot_rs1;
    i_disp_rs2   <= slot_rs2;
    i_disp_imm   <= slot_imm;
    // Sampled at the next edge
    n_edge = edge_cnt + 2;
    // Writes landed by edge N are visible to this group
    while (wr_q.size() != 0 && wr_q[0].at_edge <= n_edge) begin
      model_regs[wr_q[0].rnid] = wr_q[0].data;
      void'(wr_q.pop_front());
    end
    lane = 0;
    ill  = '0;
    for (int s = 0; s < DS; s++) begin
      if (slot_valid[s] && slot_op[s] > 4'd7) begin
        ill[s] = 1'b1;
      end else if (slot_valid[s]) begin
        ent.at_edge = n_edge + 2;
        ent.lane    = lane;
        ent.rnid    = slot_rd[s];
        ent.data    = alu_model(slot_op[s], model_regs[slot_rs1[s]],
                                model_regs[slot_rs2[s]], slot_imm[s]);
        wb_q.push_back(ent);
        ent.at_edge = n_edge + 3;
        wr_q.push_back(ent);
        lane++;
      end
    end
    if (ill != '0) begin
      ill_ent.at_edge = n_edge;
      ill_ent.mask    = ill;
      ill_q.push_back(ill_ent);
    end
    slot_valid = '0;
    slot_op    = '0;
    slot_rd    = '0;
    slot_rs1   = '0;
    slot_rs2   = '0;
    slot_imm   = '0;
  endtask

  task automatic drain();
    while (wb_q.size() != 0 || ill_q.size() != 0) begin
      issue();
    end
  endtask

  task automatic report_test(input string name, input int unsigned err_start);
    $display("test %s finished with %0d errors", name, error_cnt - err_start);
  endtask

  // ------------------------------------------------------------
  // Output monitor on the falling edge
  // ------------------------------------------------------------
  always @(negedge i_clk) begin
    edge_cnt = edge_cnt + 1;
    mon_ill  = '0;
    if (ill_q.size() != 0 && ill_q[0].at_edge == edge_cnt) begin
      mon_ill = ill_q[0].mask;
      void'(ill_q.pop_front());
    end
    check_val("o_illegal", 32'(mon_ill), 32'(o_illegal));
    mon_valid = '0;
    while (wb_q.size() != 0 && wb_q[0].at_edge == edge_cnt) begin
      mon_valid[wb_q[0].lane] = 1'b1;
      mon_rnid[wb_q[0].lane]  = wb_q[0].rnid;
      mon_data[wb_q[0].lane]  = wb_q[0].data;
      void'(wb_q.pop_front());
    end
    for (int l = 0; l < LN; l++) begin
      check_val($sformatf("o_wb_valid[%0d]", l), 32'(mon_valid[l]), 32'(o_wb_valid[l]));
      if (mon_valid[l]) begin
        check_val($sformatf("o_wb_rnid[%0d]", l), 32'(mon_rnid[l]), 32'(o_wb_rnid[l]));
        check_val($sformatf("o_wb_data[%0d]", l), mon_data[l], o_wb_data[l]);
      end
    end
    if (&o_wb_valid) begin
      busy_cnt++;
    end
  end

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------
  task automatic test_reset();
    int unsigned err_start;
    err_start = error_cnt;
    repeat (5) issue();
    set_slot(0, tile_pkg::OP_ADD, 5'd3, 5'd1, 5'd2, '0);
    issue();
    drain();
    report_test("reset", err_start);
  endtask

  task automatic test_ops();
    int unsigned err_start;
    err_start = error_cnt;
    // Load registers 1 to 8
    for (int g = 0; g < 4; g++) begin
      set_slot(0, tile_pkg::OP_LI, 5'(2 * g + 1), '0, '0, tile_pkg::imm_t'(next_rand()));
      set_slot(1, tile_pkg::OP_LI, 5'(2 * g + 2), '0, '0, tile_pkg::imm_t'(next_rand()));
      if (g == 0) begin
        slot_imm[0] = 16'hf00d;
      end
      issue();
    end
    drain();
    for (int op = 0; op < 8; op++) begin
      set_slot(0, 4'(op), 5'(9 + op), rand_src(), rand_src(), tile_pkg::imm_t'(next_rand()));
      set_slot(1, 4'(op), 5'(17 + op), rand_src(), rand_src(), tile_pkg::imm_t'(next_rand()));
      issue();
    end
    drain();
    report_test("load and operations", err_start);
  endtask

  task automatic test_steer();
    int unsigned err_start;
    int unsigned busy_start;
    err_start  = error_cnt;
    busy_start = busy_cnt;
    for (int g = 0; g < 6; g++) begin
      for (int s = 0; s < DS; s++) begin
        set_slot(s, 4'(next_rand() % 32'd8), tile_pkg::rnid_t'(next_rand()),
                 tile_pkg::rnid_t'(next_rand()), tile_pkg::rnid_t'(next_rand()),
                 tile_pkg::imm_t'(next_rand()));
      end
      issue();
    end
    // Slot 1 alone must take lane 0
    for (int g = 0; g < 4; g++) begin
      set_slot(1, 4'(next_rand() % 32'd8), tile_pkg::rnid_t'(next_rand()), rand_src(),
               rand_src(), tile_pkg::imm_t'(next_rand()));
      issue();
    end
    drain();
    check_val("cycles with both lanes busy", 32'd6, busy_cnt - busy_start);
    report_test("steering and pipelining", err_start);
  endtask

  task automatic test_illegal();
    int unsigned err_start;
    err_start = error_cnt;
    set_slot(0, tile_pkg::OP_LI, 5'd5, '0, '0, 16'h1234);
    issue();
    drain();
    for (int op = 8; op < 16; op++) begin
      set_slot(op % 2, 4'(op), 5'd5, rand_src(), rand_src(), tile_pkg::imm_t'(next_rand()));
      set_slot(1 - op % 2, tile_pkg::OP_XOR, 5'(20 + op % 4), rand_src(), rand_src(), '0);
      issue();
    end
    drain();
    // Destination of the illegal slots still holds the loaded value
    set_slot(0, tile_pkg::OP_OR, 5'd7, 5'd5, 5'd5, '0);
    issue();
    drain();
    report_test("illegal opcodes", err_start);
  endtask

  task automatic test_conflict();
    int unsigned err_start;
    err_start = error_cnt;
    set_slot(0, tile_pkg::OP_LI, 5'd12, '0, '0, 16'h5555);
    issue();
    drain();
    set_slot(0, tile_pkg::OP_LI, 5'd10, '0, '0, 16'h1111);
    set_slot(1, tile_pkg::OP_LI, 5'd10, '0, '0, 16'h2222);
    issue();
    repeat (2) issue();
    set_slot(0, tile_pkg::OP_OR, 5'd11, 5'd10, 5'd10, '0);
    issue();
    // Producer then consumers one and three cycles later
    set_slot(0, tile_pkg::OP_LI, 5'd12, '0, '0, 16'h0abc);
    issue();
    set_slot(0, tile_pkg::OP_OR, 5'd13, 5'd12, 5'd12, '0);
    issue();
    issue();
    set_slot(0, tile_pkg::OP_OR, 5'd14, 5'd12, 5'd12, '0);
    issue();
    drain();
    report_test("write conflicts and spacing", err_start);
  endtask

  // ------------------------------------------------------------
  // Main sequence and watchdog
  // ------------------------------------------------------------
  initial begin
    i_clk        = 1'b0;
    i_reset      = 1'b1;
    i_disp_valid = '0;
    i_disp_op    = '0;
    i_disp_rd    = '0;
    i_disp_rs1   = '0;
    i_disp_rs2   = '0;
    i_disp_imm   = '0;
    slot_valid   = '0;
    slot_op      = '0;
    slot_rd      = '0;
    slot_rs1     = '0;
    slot_rs2     = '0;
    slot_imm     = '0;
    edge_cnt     = 0;
    check_cnt    = 0;
    error_cnt    = 0;
    busy_cnt     = 0;
    lcg_state    = 32'h34d2;
    for (int r = 0; r < `TILE_PREG_NUM; r++) begin
      model_regs[r] = '0;
    end
    repeat (RESET_CYC) @(posedge i_clk);
    i_reset <= 1'b0;
    test_reset();
    test_ops();
    test_steer();
    test_illegal();
    test_conflict();
    $display("checks passed: %0d, failed: %0d", check_cnt - error_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the tests did not complete", WATCHDOG_CYC);
    $display("Testbench failed");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+common
common/tile_pkg.sv
common/regread_if.sv
hdl/alu_dispatch.sv
alu/alu_lane.sv
regfile/phy_regfile.sv
hdl/alu_tile.sv
tb/tb_alu_tile.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the integer tile testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_alu_tile -Mdir obj_dir
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_alu_tile)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

# Result comes from the testbench output
if echo "$sim_out" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1
